// ==== src/merge_pkg.sv ====
// Shared widths and types for the merge sort engine
// Key, address and length vectors plus the reader FSM states

package merge_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  // Keys and data words are the same thing
  parameter int KEY_W  = 32;
  parameter int ADDR_W = 16;
  parameter int LEN_W  = 16;

  //////////////////////////////
  // Types
  //////////////////////////////

  typedef logic [KEY_W-1:0]  key_t;
  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [LEN_W-1:0]  len_t;

  // Run reader FSM
  typedef enum logic [1:0] {
    READ_IDLE,
    READ_FETCH,
    READ_DRAIN
  } reader_state_e;

endpackage

// ==== src/run_reader.sv ====
// Read lane for one sorted run
// Fetches words through the shared read port into a small FIFO and streams them out

`timescale 1ns/10ps

module run_reader #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic             aclk,
  input  logic             arst_n,
  input  logic             load,
  input  merge_pkg::addr_t base,
  input  merge_pkg::len_t  len,
  output logic             rd_req,
  output merge_pkg::addr_t rd_addr,
  input  logic             rd_gnt,
  input  logic             rd_rvalid,
  input  merge_pkg::key_t  rd_rdata,
  output logic             s_valid,
  input  logic             s_ready,
  output merge_pkg::key_t  s_data,
  output logic             s_last
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [CNT_W:0] DEPTH_C = (CNT_W+1)'(FIFO_DEPTH);

  merge_pkg::reader_state_e state;
  merge_pkg::addr_t         req_addr;
  merge_pkg::len_t          req_left;
  merge_pkg::len_t          out_left;
  logic [CNT_W-1:0]         fill;
  logic [CNT_W-1:0]         inflight;
  logic [CNT_W:0]           used;
  logic [PTR_W-1:0]         wr_ptr;
  logic [PTR_W-1:0]         rd_ptr;
  merge_pkg::key_t          fifo_mem [FIFO_DEPTH];
  logic                     req_fire;
  logic                     push;
  logic                     pop;

  // Words stored plus reads still on their way back
  assign used     = {1'b0, fill} + {1'b0, inflight};
  assign rd_req   = (state == merge_pkg::READ_FETCH) && (used < DEPTH_C);
  assign rd_addr  = req_addr;
  assign req_fire = rd_req && rd_gnt;

  assign push    = rd_rvalid;
  assign pop     = s_valid && s_ready;
  assign s_valid = (fill != '0);
  assign s_data  = fifo_mem[rd_ptr];
  assign s_last  = (out_left == merge_pkg::len_t'(1));

  //////////////////////////////
  // FSM and counters
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= merge_pkg::READ_IDLE;
      req_addr <= '0;
      req_left <= '0;
      out_left <= '0;
    end else begin
      case (state)
        merge_pkg::READ_IDLE: begin
          if (load) begin
            req_addr <= base;
            req_left <= len;
            out_left <= len;
            state    <= merge_pkg::READ_FETCH;
          end
        end
        merge_pkg::READ_FETCH: begin
          if (req_fire) begin
            req_addr <= req_addr + 1'b1;
            req_left <= req_left - 1'b1;
            if (req_left == merge_pkg::len_t'(1)) begin
              state <= merge_pkg::READ_DRAIN;
            end
          end
        end
        merge_pkg::READ_DRAIN: begin
          if (pop && s_last) begin
            state <= merge_pkg::READ_IDLE;
          end
        end
        default: state <= merge_pkg::READ_IDLE;
      endcase
      if (pop) begin
        out_left <= out_left - 1'b1;
      end
    end
  end

  //////////////////////////////
  // FIFO
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      fill     <= '0;
      inflight <= '0;
      wr_ptr   <= '0;
      rd_ptr   <= '0;
    end else begin
      case ({push, pop})
        2'b10:   fill <= fill + 1'b1;
        2'b01:   fill <= fill - 1'b1;
        default: fill <= fill;
      endcase
      case ({req_fire, rd_rvalid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (push) begin
      fifo_mem[wr_ptr] <= rd_rdata;
    end
  end

  // Returned data must always find a free slot
  a_no_overflow: assert property (@(posedge aclk) disable iff (!arst_n)
    push && !pop |-> ({1'b0, fill} < DEPTH_C));

  a_len_nonzero: assert property (@(posedge aclk) disable iff (!arst_n)
    load && (state == merge_pkg::READ_IDLE) |-> (len != '0));

endmodule

// ==== src/mem_arbiter.sv ====
// Round-robin arbiter for the shared memory read port
// Holds the grant under back-pressure and routes read data back by lane tag

`timescale 1ns/10ps

module mem_arbiter #(
  parameter int NUM_LANES = 4
) (
  input  logic                               aclk,
  input  logic                               arst_n,
  input  logic             [NUM_LANES-1:0]   rd_req,
  input  merge_pkg::addr_t [NUM_LANES-1:0]   rd_addr,
  output logic             [NUM_LANES-1:0]   rd_gnt,
  output logic             [NUM_LANES-1:0]   rd_rvalid,
  output merge_pkg::key_t                    rd_rdata,
  output logic                               mem_req,
  output merge_pkg::addr_t                   mem_addr,
  input  logic                               mem_ready,
  input  logic                               mem_rvalid,
  input  merge_pkg::key_t                    mem_rdata
);

  localparam int LANE_W = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1;

  logic [LANE_W-1:0] ptr;
  logic [LANE_W-1:0] pick_idx;
  logic              pick_valid;
  logic [LANE_W-1:0] sel_idx;
  logic              sel_valid;
  logic              accept;
  logic              hold;
  logic [LANE_W-1:0] hold_idx;
  logic              tag_valid;
  logic [LANE_W-1:0] tag_idx;

  // First requester at or after the priority pointer
  always_comb begin
    logic [LANE_W-1:0] cand;
    pick_valid = 1'b0;
    pick_idx   = ptr;
    for (int i = 0; i < NUM_LANES; i++) begin
      cand = ptr + LANE_W'(i);
      if (!pick_valid && rd_req[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = cand;
      end
    end
  end

  // A stalled request keeps its lane
  assign sel_idx   = hold ? hold_idx : pick_idx;
  assign sel_valid = hold || pick_valid;
  assign mem_req   = sel_valid;
  assign mem_addr  = rd_addr[sel_idx];
  assign accept    = sel_valid && mem_ready;

  always_comb begin
    rd_gnt = '0;
    if (accept) begin
      rd_gnt[sel_idx] = 1'b1;
    end
  end

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      ptr       <= '0;
      hold      <= 1'b0;
      hold_idx  <= '0;
      tag_valid <= 1'b0;
      tag_idx   <= '0;
    end else begin
      if (accept) begin
        ptr  <= sel_idx + 1'b1;
        hold <= 1'b0;
      end else if (sel_valid) begin
        hold     <= 1'b1;
        hold_idx <= sel_idx;
      end
      tag_valid <= accept;
      tag_idx   <= sel_idx;
    end
  end

  // Read data arrives one cycle after acceptance
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rd_rvalid[i] = mem_rvalid && tag_valid && (tag_idx == LANE_W'(i));
    end
  end
  assign rd_rdata = mem_rdata;

  // A grant only ever goes to one lane that is requesting
  a_gnt_onehot: assert property (@(posedge aclk) disable iff (!arst_n)
    $onehot0(rd_gnt) && ((rd_gnt & ~rd_req) == '0));

  // Lanes keep their request up until it is taken
  a_mem_hold: assert property (@(posedge aclk) disable iff (!arst_n)
    mem_req && !mem_ready |=> mem_req && $stable(mem_addr));

endmodule

// ==== src/merge_node.sv ====
// Two-input merge of ascending streams
// Smaller key wins and ties go to input a
// Registered output slice

`timescale 1ns/10ps

module merge_node (
  input  logic            aclk,
  input  logic            arst_n,
  input  logic            a_valid,
  input  logic            a_last,
  input  merge_pkg::key_t a_data,
  output logic            a_ready,
  input  logic            b_valid,
  input  logic            b_last,
  input  merge_pkg::key_t b_data,
  output logic            b_ready,
  output logic            m_valid,
  output logic            m_last,
  output merge_pkg::key_t m_data,
  input  logic            m_ready
);

  logic            a_done;
  logic            b_done;
  logic            take_a;
  logic            take_b;
  logic            load_en;
  logic            fire_a;
  logic            fire_b;
  logic            pick_last;
  merge_pkg::key_t pick_data;

  assign load_en = !m_valid || m_ready;

  //////////////////////////////
  // Selection
  //////////////////////////////

  always_comb begin
    take_a = 1'b0;
    take_b = 1'b0;
    if (b_done) begin
      take_a = a_valid;
    end else if (a_done) begin
      take_b = b_valid;
    end else if (a_valid && b_valid) begin
      // Both heads needed before a compare
      if (a_data <= b_data) begin
        take_a = 1'b1;
      end else begin
        take_b = 1'b1;
      end
    end
  end

  assign a_ready   = load_en && take_a;
  assign b_ready   = load_en && take_b;
  assign fire_a    = a_valid && a_ready;
  assign fire_b    = b_valid && b_ready;
  assign pick_data = take_a ? a_data : b_data;
  // Group ends only when the other side has already finished
  assign pick_last = take_a ? (a_last && b_done) : (b_last && a_done);

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      a_done <= 1'b0;
      b_done <= 1'b0;
    end else if ((fire_a || fire_b) && pick_last) begin
      a_done <= 1'b0;
      b_done <= 1'b0;
    end else if (fire_a && a_last) begin
      a_done <= 1'b1;
    end else if (fire_b && b_last) begin
      b_done <= 1'b1;
    end
  end

  //////////////////////////////
  // Output slice
  //////////////////////////////

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      m_valid <= 1'b0;
    end else if (load_en) begin
      m_valid <= take_a || take_b;
    end
  end

  always_ff @(posedge aclk) begin
    if (fire_a || fire_b) begin
      m_data <= pick_data;
      m_last <= pick_last;
    end
  end

  // Upstream heads hold until this node takes them
  a_in_stable_a: assert property (@(posedge aclk) disable iff (!arst_n)
    a_valid && !a_ready |=> a_valid && $stable(a_data) && $stable(a_last));

  a_in_stable_b: assert property (@(posedge aclk) disable iff (!arst_n)
    b_valid && !b_ready |=> b_valid && $stable(b_data) && $stable(b_last));

endmodule

// ==== src/merge_tree.sv ====
// Binary tree of merge nodes
// Reduces all lane streams to one ascending stream, heap-indexed node streams

`timescale 1ns/10ps

module merge_tree #(
  parameter int NUM_LANES = 4
) (
  input  logic                            aclk,
  input  logic                            arst_n,
  input  logic            [NUM_LANES-1:0] s_valid,
  input  logic            [NUM_LANES-1:0] s_last,
  input  merge_pkg::key_t [NUM_LANES-1:0] s_data,
  output logic            [NUM_LANES-1:0] s_ready,
  output logic                            m_valid,
  output logic                            m_last,
  output merge_pkg::key_t                 m_data,
  input  logic                            m_ready
);

  localparam int LEVELS = $clog2(NUM_LANES);

  // Stream k feeds node k/2, leaves sit at NUM_LANES and above
  logic            n_valid [1:2*NUM_LANES-1];
  logic            n_last  [1:2*NUM_LANES-1];
  merge_pkg::key_t n_data  [1:2*NUM_LANES-1];
  logic            n_ready [1:2*NUM_LANES-1];

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_leaf
    assign n_valid[NUM_LANES+i] = s_valid[i];
    assign n_last[NUM_LANES+i]  = s_last[i];
    assign n_data[NUM_LANES+i]  = s_data[i];
    assign s_ready[i]           = n_ready[NUM_LANES+i];
  end

  for (genvar lvl = 0; lvl < LEVELS; lvl++) begin : g_level
    for (genvar j = 0; j < (1 << lvl); j++) begin : g_node
      localparam int K = (1 << lvl) + j;
      merge_node node_i (
        .aclk    (aclk),
        .arst_n  (arst_n),
        .a_valid (n_valid[2*K]),
        .a_last  (n_last[2*K]),
        .a_data  (n_data[2*K]),
        .a_ready (n_ready[2*K]),
        .b_valid (n_valid[2*K+1]),
        .b_last  (n_last[2*K+1]),
        .b_data  (n_data[2*K+1]),
        .b_ready (n_ready[2*K+1]),
        .m_valid (n_valid[K]),
        .m_last  (n_last[K]),
        .m_data  (n_data[K]),
        .m_ready (n_ready[K])
      );
    end
  end

  assign m_valid    = n_valid[1];
  assign m_last     = n_last[1];
  assign m_data     = n_data[1];
  assign n_ready[1] = m_ready;

endmodule

// ==== src/merge_sort_top.sv ====
// Merge sort engine top level
// Read lanes, shared port arbiter, merge tree and the busy and done control

`timescale 1ns/10ps

module merge_sort_top #(
  parameter int NUM_LANES  = 4,
  parameter int FIFO_DEPTH = 4
) (
  input  logic                              aclk,
  input  logic                              arst_n,
  input  logic                              start,
  input  merge_pkg::addr_t [NUM_LANES-1:0]  run_base,
  input  merge_pkg::len_t  [NUM_LANES-1:0]  run_len,
  output logic                              mem_req,
  output merge_pkg::addr_t                  mem_addr,
  input  logic                              mem_ready,
  input  logic                              mem_rvalid,
  input  merge_pkg::key_t                   mem_rdata,
  output logic                              out_valid,
  input  logic                              out_ready,
  output merge_pkg::key_t                   out_data,
  output logic                              out_last,
  output logic                              busy,
  output logic                              done
);

  logic                             load;
  logic                             final_xfer;
  logic             [NUM_LANES-1:0] rd_req;
  merge_pkg::addr_t [NUM_LANES-1:0] rd_addr;
  logic             [NUM_LANES-1:0] rd_gnt;
  logic             [NUM_LANES-1:0] rd_rvalid;
  merge_pkg::key_t                  rd_rdata;
  logic             [NUM_LANES-1:0] s_valid;
  logic             [NUM_LANES-1:0] s_ready;
  logic             [NUM_LANES-1:0] s_last;
  merge_pkg::key_t  [NUM_LANES-1:0] s_data;

  //////////////////////////////
  // Job control
  //////////////////////////////

  // Start only counts while idle
  assign load       = start && !busy;
  assign final_xfer = out_valid && out_ready && out_last;

  always_ff @(posedge aclk or negedge arst_n) begin
    if (!arst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      if (load) begin
        busy <= 1'b1;
      end else if (final_xfer) begin
        busy <= 1'b0;
      end
      done <= busy && final_xfer;
    end
  end

  //////////////////////////////
  // Datapath
  //////////////////////////////

  for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
    run_reader #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) reader_i (
      .aclk      (aclk),
      .arst_n    (arst_n),
      .load      (load),
      .base      (run_base[i]),
      .len       (run_len[i]),
      .rd_req    (rd_req[i]),
      .rd_addr   (rd_addr[i]),
      .rd_gnt    (rd_gnt[i]),
      .rd_rvalid (rd_rvalid[i]),
      .rd_rdata  (rd_rdata),
      .s_valid   (s_valid[i]),
      .s_ready   (s_ready[i]),
      .s_data    (s_data[i]),
      .s_last    (s_last[i])
    );
  end

  mem_arbiter #(
    .NUM_LANES (NUM_LANES)
  ) arb_i (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .rd_req     (rd_req),
    .rd_addr    (rd_addr),
    .rd_gnt     (rd_gnt),
    .rd_rvalid  (rd_rvalid),
    .rd_rdata   (rd_rdata),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata)
  );

  merge_tree #(
    .NUM_LANES (NUM_LANES)
  ) tree_i (
    .aclk    (aclk),
    .arst_n  (arst_n),
    .s_valid (s_valid),
    .s_last  (s_last),
    .s_data  (s_data),
    .s_ready (s_ready),
    .m_valid (out_valid),
    .m_last  (out_last),
    .m_data  (out_data),
    .m_ready (out_ready)
  );

  // Merged words only appear inside a job
  a_out_in_job: assert property (@(posedge aclk) disable iff (!arst_n)
    out_valid |-> busy);

endmodule

// ==== bench/tb_clock.sv ====
// Clock and reset source for the testbench
// 8 ns clock, active low reset held for a few cycles

`timescale 1ns/10ps

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 3
) (
  output logic aclk,
  output logic arst_n
);

  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Released on a falling edge, away from the flops
  initial begin
    arst_n = 1'b0;
    #(RESET_CYCLES * PERIOD_NS);
    arst_n = 1'b1;
  end

endmodule

// ==== bench/merge_sort_tb.sv ====
// Testbench for the merge sort engine
// Memory model, case table, reference merge, stream checks and watchdog

`timescale 1ns/10ps

module merge_sort_tb;

  localparam int NUM_LANES       = 4;
  localparam int FIFO_DEPTH      = 4;
  localparam int NUM_CASES       = 7;
  localparam int CYCLES_PER_WORD = 24;
  localparam int CASE_OVERHEAD   = 64;

  logic                             aclk;
  logic                             arst_n;
  logic                             start;
  merge_pkg::addr_t [NUM_LANES-1:0] run_base;
  merge_pkg::len_t  [NUM_LANES-1:0] run_len;
  logic                             mem_req;
  merge_pkg::addr_t                 mem_addr;
  logic                             mem_ready;
  logic                             mem_rvalid;
  merge_pkg::key_t                  mem_rdata;
  logic                             out_valid;
  logic                             out_ready;
  merge_pkg::key_t                  out_data;
  logic                             out_last;
  logic                             busy;
  logic                             done;

  // Case table with one row per job
  merge_pkg::addr_t case_base      [NUM_CASES][NUM_LANES];
  merge_pkg::len_t  case_len       [NUM_CASES][NUM_LANES];
  int               case_inc       [NUM_CASES];
  int               case_mem_stall [NUM_CASES];
  int               case_out_stall [NUM_CASES];
  bit               case_restart   [NUM_CASES];

  merge_pkg::key_t  mem_words [0:65535];
  merge_pkg::key_t  expected [$];
  int               rx_count;
  int               word_total;
  int               err_count;
  int               check_count;
  int               mem_stall_pct;
  int               out_stall_pct;
  bit               job_done;
  bit               table_ready;
  logic             acc_q;
  merge_pkg::addr_t acc_addr;
  logic             held;
  merge_pkg::key_t  held_data;
  logic             held_last;
  logic             last_xfer_q;

  tb_clock #(.PERIOD_NS(8), .RESET_CYCLES(3)) clk_i (.aclk(aclk), .arst_n(arst_n));

  merge_sort_top #(
    .NUM_LANES  (NUM_LANES),
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut_i (
    .aclk       (aclk),
    .arst_n     (arst_n),
    .start      (start),
    .run_base   (run_base),
    .run_len    (run_len),
    .mem_req    (mem_req),
    .mem_addr   (mem_addr),
    .mem_ready  (mem_ready),
    .mem_rvalid (mem_rvalid),
    .mem_rdata  (mem_rdata),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .out_data   (out_data),
    .out_last   (out_last),
    .busy       (busy),
    .done       (done)
  );

  task automatic report_error(input string msg);
    err_count++;
    $display("[ERROR] %0t: %s", $time, msg);
  endtask

  // inc is the largest step between neighbouring keys and 0 makes all keys equal
  task automatic set_case(input int c, input int l0, input int l1, input int l2,
                          input int l3, input int inc, input int ms, input int os,
                          input bit rs);
    int lens [NUM_LANES];
    lens = '{l0, l1, l2, l3};
    for (int i = 0; i < NUM_LANES; i++) begin
      case_base[c][i] = merge_pkg::addr_t'(c * 1024 + i * 128);
      case_len[c][i]  = merge_pkg::len_t'(lens[i]);
    end
    case_inc[c]       = inc;
    case_mem_stall[c] = ms;
    case_out_stall[c] = os;
    case_restart[c]   = rs;
  endtask

  function automatic int total_case_words();
    int sum;
    sum = 0;
    for (int c = 0; c < NUM_CASES; c++) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        sum += int'(case_len[c][i]);
      end
    end
    return sum;
  endfunction

  task automatic insert_sorted(input merge_pkg::key_t key);
    int pos;
    pos = expected.size();
    while (pos > 0 && expected[pos-1] > key) begin
      pos--;
    end
    expected.insert(pos, key);
  endtask

  // Ascending runs in memory and their sorted union
  task automatic fill_case(input int c);
    merge_pkg::key_t  key;
    merge_pkg::key_t  first;
    merge_pkg::addr_t a;
    expected.delete();
    first = merge_pkg::key_t'($urandom % 1000);
    for (int i = 0; i < NUM_LANES; i++) begin
      key = first;
      for (int w = 0; w < int'(case_len[c][i]); w++) begin
        if (w != 0) begin
          key = key + merge_pkg::key_t'($urandom % (case_inc[c] + 1));
        end
        a = case_base[c][i] + merge_pkg::addr_t'(w);
        mem_words[a] = key;
        insert_sorted(key);
      end
    end
  endtask

  //////////////////////////////
  // Memory model and ready stalls
  //////////////////////////////

  always @(negedge aclk) begin
    mem_rvalid = acc_q;
    mem_rdata  = acc_q ? mem_words[acc_addr] : '0;
    mem_ready  = int'($urandom % 100) >= mem_stall_pct;
    out_ready  = int'($urandom % 100) >= out_stall_pct;
  end

  //////////////////////////////
  // Output monitor
  //////////////////////////////

  always @(posedge aclk) begin
    if (!arst_n) begin
      acc_q       = 1'b0;
      held        = 1'b0;
      last_xfer_q = 1'b0;
    end else begin
      acc_q    = mem_req && mem_ready;
      acc_addr = mem_addr;
      if (held) begin
        check_count++;
        if (!out_valid || out_data !== held_data || out_last !== held_last) begin
          report_error("output stream changed while stalled");
        end
      end
      check_count++;
      if (done !== last_xfer_q) begin
        report_error($sformatf("done is %b, expected %b", done, last_xfer_q));
      end
      if (last_xfer_q && busy !== 1'b0) begin
        report_error("busy still high after the final transfer");
      end
      if ((mem_req || out_valid) && busy !== 1'b1) begin
        report_error($sformatf("mem_req %b out_valid %b while busy is %b",
                               mem_req, out_valid, busy));
      end
      if (out_valid && out_ready) begin
        check_count++;
        if (rx_count >= expected.size()) begin
          report_error($sformatf("extra word %08h", out_data));
        end else if (out_data !== expected[rx_count] ||
                     out_last !== (rx_count == expected.size() - 1)) begin
          report_error($sformatf("word %0d is %08h last %b, expected %08h last %b",
                                 rx_count, out_data, out_last, expected[rx_count],
                                 rx_count == expected.size() - 1));
        end
        rx_count++;
        word_total++;
      end
      held        = out_valid && !out_ready;
      held_data   = out_data;
      held_last   = out_last;
      last_xfer_q = out_valid && out_ready && out_last;
      if (done) begin
        job_done = 1'b1;
      end
    end
  end

  task automatic run_case(input int c);
    int total;
    fill_case(c);
    total         = expected.size();
    rx_count      = 0;
    job_done      = 1'b0;
    mem_stall_pct = case_mem_stall[c];
    out_stall_pct = case_out_stall[c];
    for (int i = 0; i < NUM_LANES; i++) begin
      run_base[i] = case_base[c][i];
      run_len[i]  = case_len[c][i];
    end
    start = 1'b1;
    @(negedge aclk);
    start = 1'b0;
    check_count++;
    if (busy !== 1'b1) begin
      report_error("busy did not rise after start");
    end
    if (case_restart[c]) begin
      // Second start once the short runs have drained and their lanes are idle
      while (rx_count < total / 2) begin
        @(negedge aclk);
      end
      if (busy !== 1'b1) begin
        report_error("job ended before the second start");
      end
      // Settings of a second job that must be ignored
      for (int i = 0; i < NUM_LANES; i++) begin
        run_base[i] = merge_pkg::addr_t'(16'hf000 + i * 16);
        run_len[i]  = merge_pkg::len_t'(2);
      end
      start = 1'b1;
      @(negedge aclk);
      start = 1'b0;
    end
    while (!job_done) begin
      @(negedge aclk);
    end
    repeat (4) @(negedge aclk);
    check_count++;
    if (rx_count != total || busy !== 1'b0) begin
      report_error($sformatf("case %0d got %0d words, expected %0d, busy %b",
                             c, rx_count, total, busy));
    end
    $display("case %0d: %0d words merged", c, rx_count);
  endtask

  initial begin
    void'($urandom(32'hb4d9));
    start         = 1'b0;
    run_base      = '0;
    run_len       = '0;
    mem_ready     = 1'b0;
    mem_rvalid    = 1'b0;
    mem_rdata     = '0;
    out_ready     = 1'b0;
    err_count     = 0;
    check_count   = 0;
    word_total    = 0;
    rx_count      = 0;
    mem_stall_pct = 0;
    out_stall_pct = 0;
    for (int a = 0; a < 65536; a++) begin
      mem_words[a] = {~merge_pkg::addr_t'(a), merge_pkg::addr_t'(a)};
    end
    set_case(0,  8,  8,  8,  8, 1000,  0,  0, 1'b0);
    set_case(1,  5, 12,  1,  7,  500, 30, 30, 1'b0);
    set_case(2,  6,  6,  6,  6,    0, 20, 40, 1'b0);
    set_case(3,  1,  1,  1,  1,   50, 50, 50, 1'b0);
    set_case(4, 16,  3,  9,  1,  300, 40, 20, 1'b1);
    set_case(5, 10, 10, 10, 10,    2, 25, 25, 1'b0);
    set_case(6, 16, 16, 16, 16,    3, 50, 50, 1'b0);
    table_ready = 1'b1;
    wait (arst_n);
    @(negedge aclk);
    for (int c = 0; c < NUM_CASES; c++) begin
      run_case(c);
    end
    $display("Summary: %0d checks, %0d words, %0d errors", check_count, word_total, err_count);
    if (err_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the table
  initial begin
    int limit;
    wait (table_ready);
    limit = total_case_words() * CYCLES_PER_WORD + NUM_CASES * CASE_OVERHEAD + 16;
    repeat (limit) @(posedge aclk);
    $display("Timeout: the run did not finish within %0d clock cycles", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// ==== tb.f ====
src/merge_pkg.sv
src/run_reader.sv
src/mem_arbiter.sv
src/merge_node.sv
src/merge_tree.sv
src/merge_sort_top.sv
bench/tb_clock.sv
bench/merge_sort_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the merge sort testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module merge_sort_tb -f tb.f -o merge_sort_sim

./obj_dir/merge_sort_sim | tee sim.log

if grep -qF '*** TEST FAILED ***' sim.log || ! grep -qF '*** TEST PASSED ***' sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
exit 0
